/* Makefile */
VERILATOR ?= verilator
TOP       ?= tbSsc
RTL_TOP   ?= sscTop
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing
FAIL_MSG  := ** FAIL **

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -qF '$(FAIL_MSG)' $(LOG); then exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* rtl/sscCapture.sv */
`timescale 1ns/1ps

module sscCapture (
  input  logic                          clk,
  input  logic                          rstN,
  input  logic [sscPkg::SAMPLE_W-1:0]   atod,
  input  logic                          captureEn,
  input  logic                          spectInv,
  input  logic [sscPkg::CTL_NFFT_W-1:0] nfft,
  input  logic [15:0]                   frameWait,
  input  logic                          bitTick,
  input  logic                          sendDone,
  output logic                          wrEn,
  output logic [sscPkg::BUF_AW-1:0]     wrAddr,
  output logic [sscPkg::SAMPLE_W-1:0]   wrData,
  output logic                          sendStart,
  output logic [sscPkg::BUF_AW:0]       frameLen
);

  sscPkg::seqState_t               state;
  logic [sscPkg::BUF_AW-1:0]       sampleCnt;
  logic                            invLat;
  logic [15:0]                     waitCnt;
  logic [sscPkg::CTL_NFFT_W-1:0]   nfftC;
  logic [sscPkg::BUF_AW:0]         lenNext;
  logic                            lastSample;
  logic                            waitDone;
  logic                            startFrame;
  logic [sscPkg::SAMPLE_W-1:0]     negSample;

  always_comb begin
    if (nfft < sscPkg::NFFT_MIN)
      nfftC = sscPkg::NFFT_MIN;
    else if (nfft > sscPkg::NFFT_MAX)
      nfftC = sscPkg::NFFT_MAX;
    else
      nfftC = nfft;
  end

  assign lenNext    = {{sscPkg::BUF_AW{1'b0}}, 1'b1} << nfftC;
  assign lastSample = (sampleCnt + 1'b1) == frameLen[sscPkg::BUF_AW-1:0]; // wraps at 256
  assign waitDone   = (state == sscPkg::SEQ_WAIT) && (waitCnt >= frameWait);
  assign startFrame = captureEn && ((state == sscPkg::SEQ_IDLE) || waitDone);

  // most negative sample saturates to most positive
  assign negSample = (atod == {1'b1, {(sscPkg::SAMPLE_W-1){1'b0}}}) ?
                     {1'b0, {(sscPkg::SAMPLE_W-1){1'b1}}} : -atod;

  assign wrEn   = (state == sscPkg::SEQ_CAPTURE);
  assign wrAddr = sampleCnt;
  assign wrData = (invLat && sampleCnt[0]) ? negSample : atod;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state     <= sscPkg::SEQ_IDLE;
      sampleCnt <= '0;
      invLat    <= 1'b0;
      frameLen  <= '0;
      waitCnt   <= '0;
      sendStart <= 1'b0;
    end else begin
      sendStart <= 1'b0;
      if (startFrame) begin
        state     <= sscPkg::SEQ_CAPTURE;
        sampleCnt <= '0;
        invLat    <= spectInv;                       // held for the whole frame
        frameLen  <= lenNext;
      end else begin
        case (state)
          sscPkg::SEQ_CAPTURE: begin
            sampleCnt <= sampleCnt + 1'b1;
            if (lastSample) begin
              state     <= sscPkg::SEQ_SEND;
              sendStart <= 1'b1;
            end
          end
          sscPkg::SEQ_SEND: begin
            if (sendDone) begin
              state   <= sscPkg::SEQ_WAIT;
              waitCnt <= '0;
            end
          end
          sscPkg::SEQ_WAIT: begin
            if (waitDone)
              state <= sscPkg::SEQ_IDLE;               // enable dropped
            else if (bitTick)
              waitCnt <= waitCnt + 1'b1;
          end
          default: state <= sscPkg::SEQ_IDLE;
        endcase
      end
    end
  end

endmodule

/* rtl/sscPkg.sv */
package sscPkg;

  localparam int SAMPLE_W = 14;                  // adc sample
  localparam int CH_W     = 2;
  localparam int WORD_W   = 16;                  // channel tag above sample
  localparam int ADDR_W   = 12;
  localparam int DATA_W   = 32;

  // upper nibble of the bus address
  localparam logic [3:0] SDI_SPACE       = 4'h1;
  localparam logic [3:0] VIDSWITCH_SPACE = 4'h2;
  localparam logic [3:0] SSC_SPACE       = 4'h3;
  localparam logic [3:0] DECODER_SPACE   = 4'h4;

  localparam logic [7:0] REG_BAUD_DIV   = 8'h00; // clocks per bit
  localparam logic [7:0] REG_CONTROL    = 8'h01;
  localparam logic [7:0] REG_FRAME_WAIT = 8'h02; // bit periods between frames
  localparam logic [7:0] REG_CH         = 8'h03;

  localparam int CTL_EN      = 0;
  localparam int CTL_INV     = 1;
  localparam int CTL_NFFT_LO = 2;
  localparam int CTL_NFFT_W  = 5;

  localparam logic [CTL_NFFT_W-1:0] NFFT_MIN = 5'd2;
  localparam logic [CTL_NFFT_W-1:0] NFFT_MAX = 5'd8;

  localparam int BUF_DEPTH = 256;
  localparam int BUF_AW    = 8;

  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_CAPTURE,
    SEQ_SEND,
    SEQ_WAIT
  } seqState_t;

endpackage

/* rtl/sscRegs.sv */
`timescale 1ns/1ps

module sscRegs (
  input  logic                          clk,
  input  logic                          rstN,
  input  logic                          cs,
  input  logic                          wr0,
  input  logic                          wr1,
  input  logic                          wr2,
  input  logic                          wr3,
  input  logic [sscPkg::ADDR_W-1:0]     addr,
  input  logic [sscPkg::DATA_W-1:0]     dataIn,
  output logic [sscPkg::DATA_W-1:0]     dataOut,
  output logic [15:0]                   baudDiv,
  output logic                          captureEn,
  output logic                          spectInv,
  output logic [sscPkg::CTL_NFFT_W-1:0] nfft,
  output logic [15:0]                   frameWait,
  output logic [sscPkg::CH_W-1:0]       channel
);

  logic [sscPkg::DATA_W-1:0] baudReg;
  logic [sscPkg::DATA_W-1:0] ctlReg;
  logic [sscPkg::DATA_W-1:0] waitReg;
  logic [sscPkg::DATA_W-1:0] chReg;
  logic [3:0]                wrStrb;
  logic                      inSpace;
  logic [7:0]                offset;

  assign wrStrb  = {wr3, wr2, wr1, wr0};
  assign inSpace = cs && (addr[sscPkg::ADDR_W-1 -: 4] == sscPkg::SSC_SPACE);
  assign offset  = addr[7:0];

  always_ff @(posedge clk) begin
    if (!rstN) begin
      baudReg <= '0;
      ctlReg  <= '0;
      waitReg <= '0;
      chReg   <= '0;
    end else if (inSpace) begin
      for (int i = 0; i < 4; i++) begin
        if (wrStrb[i]) begin
          case (offset)
            sscPkg::REG_BAUD_DIV:   baudReg[8*i +: 8] <= dataIn[8*i +: 8];
            sscPkg::REG_CONTROL:    ctlReg[8*i +: 8]  <= dataIn[8*i +: 8];
            sscPkg::REG_FRAME_WAIT: waitReg[8*i +: 8] <= dataIn[8*i +: 8];
            sscPkg::REG_CH:         chReg[8*i +: 8]   <= dataIn[8*i +: 8];
            default: ;                                // unknown offset
          endcase
        end
      end
    end
  end

  always_comb begin
    dataOut = '0;
    if (inSpace) begin
      case (offset)
        sscPkg::REG_BAUD_DIV:   dataOut = baudReg;
        sscPkg::REG_CONTROL:    dataOut = ctlReg;
        sscPkg::REG_FRAME_WAIT: dataOut = waitReg;
        sscPkg::REG_CH:         dataOut = chReg;
        default:                dataOut = '0;
      endcase
    end
  end

  assign baudDiv   = baudReg[15:0];
  assign captureEn = ctlReg[sscPkg::CTL_EN];
  assign spectInv  = ctlReg[sscPkg::CTL_INV];
  assign nfft      = ctlReg[sscPkg::CTL_NFFT_LO +: sscPkg::CTL_NFFT_W];
  assign frameWait = waitReg[15:0];
  assign channel   = chReg[sscPkg::CH_W-1:0];

endmodule

/* rtl/sscSampleRam.sv */
`timescale 1ns/1ps

module sscSampleRam (
  input  logic                        clk,
  input  logic                        wrEn,
  input  logic [sscPkg::BUF_AW-1:0]   wrAddr,
  input  logic [sscPkg::SAMPLE_W-1:0] wrData,
  input  logic [sscPkg::BUF_AW-1:0]   rdAddr,
  output logic [sscPkg::SAMPLE_W-1:0] rdData
);

  logic [sscPkg::SAMPLE_W-1:0] mem [0:sscPkg::BUF_DEPTH-1];

  always_ff @(posedge clk) begin
    if (wrEn)
      mem[wrAddr] <= wrData;
  end

  always_ff @(posedge clk) begin
    rdData <= mem[rdAddr];                           // one cycle latency
  end

endmodule

/* rtl/sscSerialTx.sv */
`timescale 1ns/1ps

module sscSerialTx (
  input  logic                        clk,
  input  logic                        rstN,
  input  logic [15:0]                 baudDiv,
  input  logic [sscPkg::CH_W-1:0]     channel,
  input  logic                        sendStart,
  input  logic [sscPkg::BUF_AW:0]     frameLen,
  output logic [sscPkg::BUF_AW-1:0]   rdAddr,
  input  logic [sscPkg::SAMPLE_W-1:0] rdData,
  output logic                        bitTick,
  output logic                        sendDone,
  output logic                        sdo,
  output logic                        busy
);

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_ARM,
    TX_SHIFT
  } txState_t;

  txState_t                     txState;
  logic [15:0]                  divLat;
  logic [15:0]                  divClamp;
  logic [15:0]                  baudCnt;
  logic [sscPkg::CH_W-1:0]      chLat;
  logic [sscPkg::BUF_AW:0]      lenLat;
  logic [sscPkg::BUF_AW:0]      wordCnt;
  logic [4:0]                   bitCnt;
  logic [sscPkg::WORD_W+1:0]    shiftReg;
  logic [sscPkg::WORD_W+1:0]    nextFrame;
  logic                         accept;
  logic                         lastBit;
  logic                         wordLast;
  logic                         loadWord;
  logic                         shiftBit;

  assign divClamp  = (baudDiv < 16'd2) ? 16'd2 : baudDiv;
  assign bitTick   = (baudCnt == divLat - 16'd1);
  assign accept    = (txState == TX_IDLE) && sendStart;
  assign nextFrame = {1'b1, chLat, rdData, 1'b0};    // stop, tag, sample, start
  assign lastBit   = (bitCnt == sscPkg::WORD_W + 1);
  assign wordLast  = (wordCnt + 1'b1) == lenLat;
  assign loadWord  = bitTick && ((txState == TX_ARM) ||
                                 (txState == TX_SHIFT && lastBit && !wordLast));
  assign shiftBit  = bitTick && (txState == TX_SHIFT) && !lastBit;

  assign busy = (txState == TX_SHIFT);
  assign sdo  = busy ? shiftReg[0] : 1'b1;

  // free running, realigned on each frame
  always_ff @(posedge clk) begin
    if (!rstN) begin
      baudCnt <= '0;
      divLat  <= 16'd2;
    end else begin
      if (accept)
        divLat <= divClamp;
      if (sendStart || bitTick)
        baudCnt <= '0;
      else
        baudCnt <= baudCnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      chLat  <= channel;
      lenLat <= frameLen;
    end
    if (loadWord)
      shiftReg <= nextFrame;
    else if (shiftBit)
      shiftReg <= shiftReg >> 1;                     // lsb first
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      txState  <= TX_IDLE;
      rdAddr   <= '0;
      wordCnt  <= '0;
      bitCnt   <= '0;
      sendDone <= 1'b0;
    end else begin
      sendDone <= 1'b0;
      if (accept) begin
        txState <= TX_ARM;
        rdAddr  <= '0;
        wordCnt <= '0;
      end
      if (loadWord) begin
        txState <= TX_SHIFT;
        rdAddr  <= rdAddr + 1'b1;                    // prefetch next word
        bitCnt  <= '0;
        if (txState == TX_SHIFT)
          wordCnt <= wordCnt + 1'b1;
      end else if (shiftBit) begin
        bitCnt <= bitCnt + 1'b1;
      end else if (bitTick && busy && lastBit) begin
        txState  <= TX_IDLE;                         // end of last stop bit
        sendDone <= 1'b1;
      end
    end
  end

endmodule

/* rtl/sscTop.sv */
`timescale 1ns/1ps

module sscTop (
  input  logic                        clk,
  input  logic                        rstN,
  input  logic [sscPkg::SAMPLE_W-1:0] atod,
  input  logic                        cs,
  input  logic                        wr0,
  input  logic                        wr1,
  input  logic                        wr2,
  input  logic                        wr3,
  input  logic [sscPkg::ADDR_W-1:0]   addr,
  input  logic [sscPkg::DATA_W-1:0]   dataIn,
  output logic [sscPkg::DATA_W-1:0]   dataOut,
  output logic                        sdo,
  output logic                        busy
);

  logic [15:0]                   baudDiv;
  logic                          captureEn;
  logic                          spectInv;
  logic [sscPkg::CTL_NFFT_W-1:0] nfft;
  logic [15:0]                   frameWait;
  logic [sscPkg::CH_W-1:0]       channel;
  logic                          wrEn;
  logic [sscPkg::BUF_AW-1:0]     wrAddr;
  logic [sscPkg::SAMPLE_W-1:0]   wrData;
  logic [sscPkg::BUF_AW-1:0]     rdAddr;
  logic [sscPkg::SAMPLE_W-1:0]   rdData;
  logic                          sendStart;
  logic [sscPkg::BUF_AW:0]       frameLen;
  logic                          sendDone;
  logic                          bitTick;

  sscRegs uRegs (
    .clk(clk), .rstN(rstN),
    .cs(cs), .wr0(wr0), .wr1(wr1), .wr2(wr2), .wr3(wr3),
    .addr(addr), .dataIn(dataIn), .dataOut(dataOut),
    .baudDiv(baudDiv), .captureEn(captureEn), .spectInv(spectInv),
    .nfft(nfft), .frameWait(frameWait), .channel(channel)
  );

  sscCapture uCapture (
    .clk(clk), .rstN(rstN), .atod(atod),
    .captureEn(captureEn), .spectInv(spectInv), .nfft(nfft), .frameWait(frameWait),
    .bitTick(bitTick), .sendDone(sendDone),
    .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
    .sendStart(sendStart), .frameLen(frameLen)
  );

  sscSampleRam uRam (
    .clk(clk), .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
    .rdAddr(rdAddr), .rdData(rdData)
  );

  sscSerialTx uTx (
    .clk(clk), .rstN(rstN), .baudDiv(baudDiv), .channel(channel),
    .sendStart(sendStart), .frameLen(frameLen),
    .rdAddr(rdAddr), .rdData(rdData),
    .bitTick(bitTick), .sendDone(sendDone), .sdo(sdo), .busy(busy)
  );

endmodule

/* sim.f */
rtl/sscPkg.sv
rtl/sscRegs.sv
rtl/sscCapture.sv
rtl/sscSampleRam.sv
rtl/sscSerialTx.sv
rtl/sscTop.sv
verif/ssc_assert.sv
verif/tbSsc.sv

/* verif/ssc_assert.sv */
`timescale 1ns/1ps

module sscTxChecks (
  input logic clk,
  input logic rstN,
  input logic sdo,
  input logic busy,
  input logic sendDone,
  input logic bitTick
);

  // line leaves a frame on a stop bit
  stopBeforeIdle: assert property (@(posedge clk) disable iff (!rstN) $fell(busy) |-> $past(sdo))
    else $error("sdo low in the last bit before busy fell");

  donePulse: assert property (@(posedge clk) disable iff (!rstN) sendDone |=> !sendDone)
    else $error("sendDone held for more than one cycle");

  // divider never below 2 keeps ticks apart
  tickSpacing: assert property (@(posedge clk) disable iff (!rstN) bitTick |=> !bitTick)
    else $error("bitTick on two consecutive cycles");

endmodule

bind sscSerialTx sscTxChecks uTxChecks (
  .clk(clk), .rstN(rstN), .sdo(sdo), .busy(busy), .sendDone(sendDone), .bitTick(bitTick)
);

/* verif/tbSsc.sv */
`timescale 1ns/1ps

module tbSsc;

  typedef struct {
    logic [15:0] baudDiv;
    logic [4:0]  nfft;
    logic        inv;
    logic [1:0]  ch;
    logic [15:0] frameWait;
    int          frames;
    int          words;                              // expected per frame
  } stimRow_t;

  localparam int NROWS = 6;

  logic                        clk = 1'b0;
  logic                        rstN;
  logic [sscPkg::SAMPLE_W-1:0] atod;
  logic                        cs;
  logic                        wr0;
  logic                        wr1;
  logic                        wr2;
  logic                        wr3;
  logic [sscPkg::ADDR_W-1:0]   addr;
  logic [sscPkg::DATA_W-1:0]   dataIn;
  logic [sscPkg::DATA_W-1:0]   dataOut;
  logic                        sdo;
  logic                        busy;

  stimRow_t    rows [NROWS];
  logic [13:0] sampleLog [int];                      // keyed by cycle
  logic [15:0] rxWords [$];
  int          cycle = 0;
  int          cycleLimit = 1000000;
  int          forceAt = -1;
  int          wrCycle;
  int          errors = 0;
  int          checks = 0;

  sscTop u_dut (
    .clk(clk), .rstN(rstN), .atod(atod), .cs(cs),
    .wr0(wr0), .wr1(wr1), .wr2(wr2), .wr3(wr3),
    .addr(addr), .dataIn(dataIn), .dataOut(dataOut), .sdo(sdo), .busy(busy)
  );

  always #20 clk = ~clk;

  // sample driven here is taken by the DUT at the next edge
  always @(posedge clk) begin
    logic [13:0] smp;
    smp = (cycle == forceAt) ? 14'h2000 : 14'($urandom);
    atod <= smp;
    sampleLog[cycle] = smp;
    cycle <= cycle + 1;
  end

  always @(posedge clk) begin
    if (cycle > cycleLimit) begin
      errors++;
      $display("timeout after %0d cycles, the DUT never finished", cycle);
      closeRun();
    end
  end

  task automatic closeRun();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  endtask

  task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp)
      else begin
        errors++;
        $display("** Error: %s expected 0x%0h actual 0x%0h", name, exp, got);
      end
  endtask

  task automatic checkTrue(input logic cond, input string what);
    checks++;
    assert (cond)
      else begin
        errors++;
        $display("Error: %s", what);
      end
  endtask

  function automatic logic [31:0] mergeBytes(input logic [31:0] old, input logic [31:0] data,
                                             input logic [3:0] strb);
    logic [31:0] res;
    res = old;
    for (int i = 0; i < 4; i++)
      if (strb[i])
        res[8*i +: 8] = data[8*i +: 8];
    return res;
  endfunction

  function automatic logic [13:0] satNeg(input logic [13:0] s);
    if (s == 14'h2000)
      return 14'h1fff;                               // most negative saturates
    return -s;
  endfunction

  function automatic logic [15:0] expWord(input int logIdx, input int pos, input logic [1:0] ch,
                                          input logic inv);
    logic [13:0] s;
    s = sampleLog[logIdx];
    if (inv && (pos % 2 == 1))
      s = satNeg(s);
    return {ch, s};
  endfunction

  task automatic busWrite(input logic [3:0] space, input logic [7:0] off,
                          input logic [31:0] data, input logic [3:0] strb);
    @(posedge clk);
    wrCycle = cycle;
    cs <= 1'b1;
    addr <= {space, off};
    dataIn <= data;
    {wr3, wr2, wr1, wr0} <= strb;
    @(posedge clk);
    cs <= 1'b0;
    {wr3, wr2, wr1, wr0} <= 4'h0;
  endtask

  task automatic busRead(input logic [7:0] off, output logic [31:0] data);
    @(posedge clk);
    cs <= 1'b1;
    addr <= {sscPkg::SSC_SPACE, off};
    @(posedge clk);
    data = dataOut;
    cs <= 1'b0;
  endtask

  // samples sdo at mid-bit using the expected divider
  task automatic receiveFrame(input int words, input int div, output int riseCyc,
                              output int fallCyc);
    logic [17:0] bits;
    rxWords.delete();
    do @(posedge clk); while (busy !== 1'b1);
    riseCyc = cycle;
    repeat ((div - 1) / 2) @(posedge clk);
    for (int w = 0; w < words; w++) begin
      for (int b = 0; b < 18; b++) begin
        if (w + b > 0)
          repeat (div) @(posedge clk);
        bits[b] = sdo;
      end
      checkEq($sformatf("sdo start bit %0d", w), {31'h0, bits[0]}, 32'h0);
      checkEq($sformatf("sdo stop bit %0d", w), {31'h0, bits[17]}, 32'h1);
      rxWords.push_back(bits[16:1]);
    end
    do @(posedge clk); while (busy === 1'b1);
    fallCyc = cycle;
    checkEq("busy clocks", fallCyc - riseCyc, words * 18 * div);
  endtask

  task automatic compareFrame(input int base, input logic [1:0] ch, input logic inv);
    for (int i = 0; i < rxWords.size(); i++)
      checkEq($sformatf("sdo word %0d", i), {16'h0, rxWords[i]},
              {16'h0, expWord(base + i, i, ch, inv)});
  endtask

  initial begin
    stimRow_t    row;
    logic [31:0] shadow;
    logic [31:0] rd;
    logic [31:0] ctl;
    logic [3:0]  foreign [3];
    int          div;
    int          base;
    int          rise;
    int          fall;
    int          rise2;
    int          fall2;
    int          seen;

    void'($urandom(32'h91be_ec3e));
    rstN = 1'b0;
    atod = '0;
    cs = 1'b0;
    {wr3, wr2, wr1, wr0} = 4'h0;
    addr = '0;
    dataIn = '0;

    // baudDiv nfft inv ch frameWait frames words
    rows[0] = '{16'd2, 5'd2, 1'b0, 2'd1, 16'd3, 2, 4};
    rows[1] = '{16'd5, 5'd4, 1'b0, 2'd2, 16'd4, 1, 16};
    rows[2] = '{16'd0, 5'd3, 1'b1, 2'd3, 16'd3, 2, 8};
    rows[3] = '{16'd3, 5'd8, 1'b0, 2'd0, 16'd3, 1, 256};
    rows[4] = '{16'd1, 5'd1, 1'b1, 2'd1, 16'd6, 2, 4};   // clamped up
    rows[5] = '{16'd2, 5'd20, 1'b1, 2'd2, 16'd3, 1, 256}; // clamped down
    foreign = '{sscPkg::SDI_SPACE, sscPkg::VIDSWITCH_SPACE, sscPkg::DECODER_SPACE};

    cycleLimit = 600;
    foreach (rows[r]) begin
      div = (rows[r].baudDiv < 2) ? 2 : int'(rows[r].baudDiv);
      cycleLimit += rows[r].frames * (rows[r].words * (18 * div + 2) + rows[r].frameWait * div)
                    + rows[r].frameWait * div + 4 * div + 100;
    end

    repeat (16) @(posedge clk);
    rstN <= 1'b1;

    busWrite(sscPkg::SSC_SPACE, sscPkg::REG_FRAME_WAIT, 32'h1234_5678, 4'hf);
    shadow = 32'h1234_5678;
    busWrite(sscPkg::SSC_SPACE, sscPkg::REG_FRAME_WAIT, 32'haaaa_bbcc, 4'b0010);
    shadow = mergeBytes(shadow, 32'haaaa_bbcc, 4'b0010);
    foreach (foreign[i])
      busWrite(foreign[i], sscPkg::REG_FRAME_WAIT, 32'hffff_ffff, 4'hf);
    busRead(sscPkg::REG_FRAME_WAIT, rd);
    checkEq("dataOut frame wait", rd, shadow);
    busWrite(sscPkg::SSC_SPACE, sscPkg::REG_CH, 32'h0403_0201, 4'b0101);
    busRead(sscPkg::REG_CH, rd);
    checkEq("dataOut channel", rd, mergeBytes(32'h0, 32'h0403_0201, 4'b0101));

    for (int r = 0; r < NROWS; r++) begin
      row = rows[r];
      div = (row.baudDiv < 2) ? 2 : int'(row.baudDiv);
      busWrite(sscPkg::SSC_SPACE, sscPkg::REG_BAUD_DIV, {16'h0, row.baudDiv}, 4'hf);
      busWrite(sscPkg::SSC_SPACE, sscPkg::REG_FRAME_WAIT, {16'h0, row.frameWait}, 4'hf);
      busWrite(sscPkg::SSC_SPACE, sscPkg::REG_CH, {30'h0, row.ch}, 4'hf);
      ctl = {25'h0, row.nfft, row.inv, 1'b1};
      busWrite(sscPkg::SSC_SPACE, sscPkg::REG_CONTROL, ctl, 4'hf);
      base = wrCycle + 2;                            // first captured sample
      if (row.inv)
        forceAt = wrCycle + 3;
      receiveFrame(row.words, div, rise, fall);
      compareFrame(base, row.ch, row.inv);
      if (row.frames > 1) begin
        receiveFrame(row.words, div, rise2, fall2);
        checkTrue(rise2 - fall >= row.frameWait * div,
                  $sformatf("row %0d gap of %0d clocks is shorter than the frame wait",
                            r, rise2 - fall));
        // capture restarts frameWait bit periods after the last stop bit
        compareFrame(fall + row.frameWait * div, row.ch, row.inv);
      end
      busWrite(sscPkg::SSC_SPACE, sscPkg::REG_CONTROL, {ctl[31:1], 1'b0}, 4'h1);
      seen = 0;
      repeat (row.frameWait * div + row.words + 4 * div + 20) begin
        @(posedge clk);
        if (busy)
          seen++;
      end
      checkEq($sformatf("busy after disable, row %0d", r), seen, 0);
    end

    closeRun();
  end

endmodule
